//--- source/core_pkg.sv
// core shared definitions
`default_nettype none

package core_pkg;

  // data and address word
  typedef logic [63:0] xlen_t;
  // raw instruction word
  typedef logic [31:0] inst_t;
  // integer register index
  typedef logic [4:0] reg_idx_t;

  // one instruction takes all eight phases
  typedef enum logic [2:0] {
    PH_FETCH  = 3'd0,
    PH_DECODE = 3'd1,
    PH_EXEC   = 3'd2,
    PH_MEM    = 3'd3,
    PH_WB     = 3'd4,
    PH_IDLE5  = 3'd5,
    PH_IDLE6  = 3'd6,
    PH_COMMIT = 3'd7
  } phase_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_t;

  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  // custom opcode that stops the core
  localparam logic [6:0] OPC_TRAP   = 7'h6b;

  localparam xlen_t PC_START   = 64'h0;
  localparam int    DMEM_WORDS = 32;

endpackage

`default_nettype wire

//--- source/phase_counter.sv
// instruction phase counter
`timescale 1ns/10ps
`default_nettype none

module phase_counter (
  input  wire                  clock,
  input  wire                  reset,
  input  wire logic            halt_i,
  output core_pkg::phase_t     phase_o
);

  // 3-bit wrap takes PH_COMMIT back to PH_FETCH
  always_ff @(posedge clock) begin
    if (reset) begin
      phase_o <= core_pkg::PH_FETCH;
    end else if (!halt_i) begin
      phase_o <= core_pkg::phase_t'(phase_o + 3'd1);
    end
  end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
// instruction fetch
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
  input  wire                    clock,
  input  wire                    reset,
  input  wire core_pkg::phase_t  phase_i,
  input  wire logic              jmp_i,
  input  wire core_pkg::xlen_t   jmp_addr_i,
  input  wire core_pkg::inst_t   imem_data_i,
  output core_pkg::xlen_t        imem_addr_o,
  output core_pkg::xlen_t        pc_o,
  output core_pkg::inst_t        inst_o
);

  // memory is read straight from the pc
  assign imem_addr_o = pc_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_o <= core_pkg::PC_START;
    end else if (phase_i == core_pkg::PH_COMMIT) begin
      pc_o <= jmp_i ? jmp_addr_i : pc_o + 64'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_o <= '0;
    end else if (phase_i == core_pkg::PH_FETCH) begin
      inst_o <= imem_data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
// instruction decode
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  wire                    clock,
  input  wire                    reset,
  input  wire core_pkg::phase_t  phase_i,
  input  wire core_pkg::inst_t   inst_i,
  input  wire core_pkg::xlen_t   pc_i,
  input  wire core_pkg::xlen_t   rs1_data_i,
  input  wire core_pkg::xlen_t   rs2_data_i,
  output core_pkg::reg_idx_t     rs1_o,
  output core_pkg::reg_idx_t     rs2_o,
  output core_pkg::reg_idx_t     rd_o,
  output core_pkg::xlen_t        op1_o,
  output core_pkg::xlen_t        op2_o,
  output core_pkg::xlen_t        store_data_o,
  output core_pkg::alu_op_t      alu_op_o,
  output logic                   is_branch_o,
  output logic                   branch_ne_o,
  output logic                   is_jal_o,
  output logic                   mem_ren_o,
  output logic                   mem_wen_o,
  output logic                   rd_wen_o,
  output logic                   is_trap_o,
  output core_pkg::xlen_t        offset_o
);

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  core_pkg::xlen_t   imm_i, imm_s, imm_b, imm_j, imm_u;
  core_pkg::xlen_t   op1_d, op2_d;
  core_pkg::alu_op_t alu_d;
  logic              is_op_imm, is_op, is_lui, is_load, is_store, is_br, is_jal;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};

  assign is_op_imm = opcode == core_pkg::OPC_OP_IMM;
  assign is_op     = opcode == core_pkg::OPC_OP;
  assign is_lui    = opcode == core_pkg::OPC_LUI;
  assign is_load   = opcode == core_pkg::OPC_LOAD;
  assign is_store  = opcode == core_pkg::OPC_STORE;
  // only beq and bne
  assign is_br     = (opcode == core_pkg::OPC_BRANCH) && (funct3[2:1] == 2'b00);
  assign is_jal    = opcode == core_pkg::OPC_JAL;

  always_comb begin
    op1_d = rs1_data_i;
    op2_d = rs2_data_i;
    alu_d = core_pkg::ALU_ADD;
    if (is_op_imm || is_op) begin
      case (funct3)
        3'b111:  alu_d = core_pkg::ALU_AND;
        3'b110:  alu_d = core_pkg::ALU_OR;
        3'b100:  alu_d = core_pkg::ALU_XOR;
        default: alu_d = (is_op && inst_i[30]) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      endcase
    end
    if (is_op_imm || is_load) begin
      op2_d = imm_i;
    end else if (is_store) begin
      op2_d = imm_s;
    end else if (is_lui) begin
      op1_d = '0;
      op2_d = imm_u;
    end else if (is_jal) begin
      // link value pc+4 comes out of the alu
      op1_d = pc_i;
      op2_d = 64'd4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      is_branch_o <= 1'b0;
      branch_ne_o <= 1'b0;
      is_jal_o    <= 1'b0;
      mem_ren_o   <= 1'b0;
      mem_wen_o   <= 1'b0;
      rd_wen_o    <= 1'b0;
      is_trap_o   <= 1'b0;
      alu_op_o    <= core_pkg::ALU_ADD;
    end else if (phase_i == core_pkg::PH_DECODE) begin
      is_branch_o <= is_br;
      branch_ne_o <= funct3[0];
      is_jal_o    <= is_jal;
      mem_ren_o   <= is_load;
      mem_wen_o   <= is_store;
      rd_wen_o    <= is_op_imm | is_op | is_lui | is_load | is_jal;
      is_trap_o   <= opcode == core_pkg::OPC_TRAP;
      alu_op_o    <= alu_d;
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == core_pkg::PH_DECODE) begin
      rd_o         <= inst_i[11:7];
      op1_o        <= op1_d;
      op2_o        <= op2_d;
      store_data_o <= rs2_data_i;
      offset_o     <= is_jal ? imm_j : imm_b;
    end
  end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
// alu and branch unit
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
  input  wire                     clock,
  input  wire                     reset,
  input  wire core_pkg::phase_t   phase_i,
  input  wire core_pkg::xlen_t    op1_i,
  input  wire core_pkg::xlen_t    op2_i,
  input  wire core_pkg::alu_op_t  alu_op_i,
  input  wire core_pkg::xlen_t    rs1_data_i,
  input  wire core_pkg::xlen_t    rs2_data_i,
  input  wire core_pkg::xlen_t    pc_i,
  input  wire core_pkg::xlen_t    offset_i,
  input  wire logic               is_branch_i,
  input  wire logic               branch_ne_i,
  input  wire logic               is_jal_i,
  output core_pkg::xlen_t         alu_result_o,
  output logic                    jmp_o,
  output core_pkg::xlen_t         jmp_addr_o
);

  core_pkg::xlen_t alu_d;
  logic            equal;
  logic            taken;

  always_comb begin
    case (alu_op_i)
      core_pkg::ALU_SUB: alu_d = op1_i - op2_i;
      core_pkg::ALU_AND: alu_d = op1_i & op2_i;
      core_pkg::ALU_OR:  alu_d = op1_i | op2_i;
      core_pkg::ALU_XOR: alu_d = op1_i ^ op2_i;
      default:           alu_d = op1_i + op2_i;
    endcase
  end

  // bne takes the branch on a mismatch
  assign equal = rs1_data_i == rs2_data_i;
  assign taken = is_jal_i | (is_branch_i & (equal ^ branch_ne_i));

  always_ff @(posedge clock) begin
    if (reset) begin
      jmp_o <= 1'b0;
    end else if (phase_i == core_pkg::PH_EXEC) begin
      jmp_o <= taken;
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == core_pkg::PH_EXEC) begin
      alu_result_o <= alu_d;
      jmp_addr_o   <= pc_i + offset_i;
    end
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
// integer register file
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire                      clock,
  input  wire                      reset,
  input  wire core_pkg::reg_idx_t  rs1_i,
  input  wire core_pkg::reg_idx_t  rs2_i,
  input  wire core_pkg::reg_idx_t  rd_i,
  input  wire logic                wen_i,
  input  wire core_pkg::xlen_t     wdata_i,
  output core_pkg::xlen_t          rs1_data_o,
  output core_pkg::xlen_t          rs2_data_o,
  output core_pkg::xlen_t          a0_o
);

  core_pkg::xlen_t regs [32];

  // x0 is never written so it stays zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (rd_i != 5'd0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];
  assign a0_o       = regs[10];

endmodule

`default_nettype wire

//--- source/mem_stage.sv
// data memory and writeback select
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
  input  wire                    clock,
  input  wire                    reset,
  input  wire core_pkg::phase_t  phase_i,
  input  wire logic              ren_i,
  input  wire logic              wen_i,
  input  wire core_pkg::xlen_t   addr_i,
  input  wire core_pkg::xlen_t   wdata_i,
  input  wire core_pkg::xlen_t   ex_result_i,
  input  wire logic              ex_wen_i,
  output logic                   rd_wen_o,
  output core_pkg::xlen_t        rd_wdata_o
);

  core_pkg::xlen_t ram [core_pkg::DMEM_WORDS];
  core_pkg::xlen_t load_q;
  logic [4:0]      word;

  // doubleword index
  assign word = addr_i[7:3];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::DMEM_WORDS; i++) begin
        ram[i] <= '0;
      end
    end else if (phase_i == core_pkg::PH_MEM && wen_i) begin
      ram[word] <= wdata_i;
    end
  end

  always_ff @(posedge clock) begin
    if (phase_i == core_pkg::PH_MEM && ren_i) begin
      load_q <= ram[word];
    end
  end

  // data stays valid past wb, so commit can sample it
  assign rd_wdata_o = ren_i ? load_q : ex_result_i;
  assign rd_wen_o   = ex_wen_i && (phase_i == core_pkg::PH_WB);

endmodule

`default_nettype wire

//--- source/core_top.sv
// multi-cycle rv64i core
`timescale 1ns/10ps
`default_nettype none

module core_top (
  input  wire                    clock,
  input  wire                    reset,
  output core_pkg::xlen_t        imem_addr_o,
  input  wire core_pkg::inst_t   imem_data_i,
  output logic                   commit_valid_o,
  output core_pkg::xlen_t        commit_pc_o,
  output core_pkg::inst_t        commit_inst_o,
  output logic                   commit_wen_o,
  output core_pkg::reg_idx_t     commit_wdest_o,
  output core_pkg::xlen_t        commit_wdata_o,
  output logic                   trap_o,
  output logic [7:0]             trap_code_o,
  output core_pkg::xlen_t        cycle_count_o,
  output core_pkg::xlen_t        instr_count_o
);

  core_pkg::phase_t   phase;
  core_pkg::xlen_t    pc, jmp_addr, op1, op2, store_data, offset, alu_result;
  core_pkg::xlen_t    rs1_data, rs2_data, a0, rd_wdata;
  core_pkg::inst_t    inst;
  core_pkg::reg_idx_t rs1, rs2, rd;
  core_pkg::alu_op_t  alu_op;
  logic               jmp, is_branch, branch_ne, is_jal, mem_ren, mem_wen;
  logic               dec_rd_wen, is_trap, rd_wen, retire;

  phase_counter u_phase (
    .clock   (clock),
    .reset   (reset),
    .halt_i  (trap_o),
    .phase_o (phase)
  );

  fetch_stage u_fetch (
    .clock       (clock),
    .reset       (reset),
    .phase_i     (phase),
    .jmp_i       (jmp),
    .jmp_addr_i  (jmp_addr),
    .imem_data_i (imem_data_i),
    .imem_addr_o (imem_addr_o),
    .pc_o        (pc),
    .inst_o      (inst)
  );

  decode_stage u_decode (
    .clock        (clock),
    .reset        (reset),
    .phase_i      (phase),
    .inst_i       (inst),
    .pc_i         (pc),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rd_o         (rd),
    .op1_o        (op1),
    .op2_o        (op2),
    .store_data_o (store_data),
    .alu_op_o     (alu_op),
    .is_branch_o  (is_branch),
    .branch_ne_o  (branch_ne),
    .is_jal_o     (is_jal),
    .mem_ren_o    (mem_ren),
    .mem_wen_o    (mem_wen),
    .rd_wen_o     (dec_rd_wen),
    .is_trap_o    (is_trap),
    .offset_o     (offset)
  );

  execute_stage u_execute (
    .clock        (clock),
    .reset        (reset),
    .phase_i      (phase),
    .op1_i        (op1),
    .op2_i        (op2),
    .alu_op_i     (alu_op),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .pc_i         (pc),
    .offset_i     (offset),
    .is_branch_i  (is_branch),
    .branch_ne_i  (branch_ne),
    .is_jal_i     (is_jal),
    .alu_result_o (alu_result),
    .jmp_o        (jmp),
    .jmp_addr_o   (jmp_addr)
  );

  reg_file u_regs (
    .clock      (clock),
    .reset      (reset),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rd_i       (rd),
    .wen_i      (rd_wen),
    .wdata_i    (rd_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .a0_o       (a0)
  );

  mem_stage u_mem (
    .clock       (clock),
    .reset       (reset),
    .phase_i     (phase),
    .ren_i       (mem_ren),
    .wen_i       (mem_wen),
    .addr_i      (alu_result),
    .wdata_i     (store_data),
    .ex_result_i (alu_result),
    .ex_wen_i    (dec_rd_wen),
    .rd_wen_o    (rd_wen),
    .rd_wdata_o  (rd_wdata)
  );

  // the phase counter halts after a trap so no commit edge follows
  assign retire = phase == core_pkg::PH_COMMIT;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid_o <= 1'b0;
      trap_o         <= 1'b0;
      trap_code_o    <= '0;
      cycle_count_o  <= '0;
      instr_count_o  <= '0;
    end else begin
      commit_valid_o <= retire;
      if (!trap_o) begin
        cycle_count_o <= cycle_count_o + 64'd1;
      end
      if (retire) begin
        instr_count_o <= instr_count_o + 64'd1;
      end
      if (retire && is_trap) begin
        trap_o      <= 1'b1;
        trap_code_o <= a0[7:0];
      end
    end
  end

  // commit payload is qualified by commit_valid_o
  always_ff @(posedge clock) begin
    if (retire) begin
      commit_pc_o    <= pc;
      commit_inst_o  <= inst;
      commit_wen_o   <= dec_rd_wen;
      commit_wdest_o <= rd;
      commit_wdata_o <= rd_wdata;
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_program.svh
// test program image
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic core_pkg::inst_t alu_imm(input int f3, input int rd, input int rs1,
                                            input int imm);
  return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), core_pkg::OPC_OP_IMM};
endfunction

function automatic core_pkg::inst_t alu_reg(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
  return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), core_pkg::OPC_OP};
endfunction

function automatic core_pkg::inst_t upper_imm(input int rd, input int imm20);
  return {20'(imm20), 5'(rd), core_pkg::OPC_LUI};
endfunction

function automatic core_pkg::inst_t load_dw(input int rd, input int rs1, input int imm);
  return {12'(imm), 5'(rs1), 3'b011, 5'(rd), core_pkg::OPC_LOAD};
endfunction

function automatic core_pkg::inst_t store_dw(input int rs2, input int rs1, input int imm);
  logic [11:0] v;
  v = 12'(imm);
  return {v[11:5], 5'(rs2), 5'(rs1), 3'b011, v[4:0], core_pkg::OPC_STORE};
endfunction

// f3 0 is beq, 1 is bne
function automatic core_pkg::inst_t branch_rel(input int f3, input int rs1, input int rs2,
                                               input int off);
  logic [12:0] v;
  v = 13'(off);
  return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], core_pkg::OPC_BRANCH};
endfunction

function automatic core_pkg::inst_t jump_link(input int rd, input int off);
  logic [20:0] v;
  v = 21'(off);
  return {v[20], v[10:1], v[11], v[19:12], 5'(rd), core_pkg::OPC_JAL};
endfunction

function automatic core_pkg::inst_t trap_inst();
  return {25'd0, core_pkg::OPC_TRAP};
endfunction

task automatic load_program();
  // unused slots hold an unknown opcode tagged with the word address
  for (int i = 0; i < 64; i++) begin
    rom[i] = {25'(i), 7'h0b};
  end
  prog_len = 0;
  append_inst(alu_imm(0, 1, 0, rand_bits(12)));
  append_inst(alu_imm(0, 2, 1, rand_bits(12)));
  append_inst(alu_imm(7, 3, 2, rand_bits(12)));
  append_inst(alu_imm(6, 4, 3, rand_bits(12)));
  append_inst(alu_imm(4, 5, 4, rand_bits(12)));
  append_inst(upper_imm(6, rand_bits(20)));
  append_inst(alu_reg(0, 0, 7, 6, 5));
  append_inst(alu_reg(32, 0, 8, 7, 2));
  append_inst(alu_reg(0, 7, 9, 8, 4));
  append_inst(alu_reg(0, 6, 11, 9, 1));
  append_inst(alu_reg(0, 4, 12, 11, 6));
  // write to x0, then read it back
  append_inst(alu_imm(0, 0, 1, rand_bits(12)));
  append_inst(alu_reg(0, 0, 13, 0, 2));
  // fence retires with no write
  append_inst(32'h0000000f);
  append_inst(alu_imm(0, 14, 0, 64));
  append_inst(store_dw(7, 14, 0));
  append_inst(store_dw(12, 14, 8));
  append_inst(store_dw(6, 14, -16));
  append_inst(load_dw(15, 14, 0));
  append_inst(load_dw(16, 14, 8));
  append_inst(load_dw(17, 14, -16));
  append_inst(store_dw(8, 0, 120));
  append_inst(load_dw(18, 0, 120));
  append_inst(branch_rel(0, 15, 7, 8));
  append_inst(alu_imm(0, 19, 0, 1));
  append_inst(branch_rel(1, 15, 7, 8));
  append_inst(branch_rel(0, 16, 7, 8));
  append_inst(branch_rel(1, 16, 7, 8));
  append_inst(alu_imm(0, 19, 0, 2));
  append_inst(jump_link(20, 12));
  append_inst(alu_imm(0, 19, 0, 3));
  append_inst(alu_imm(0, 19, 0, 4));
  append_inst(alu_imm(0, 10, 20, rand_bits(12)));
  append_inst(trap_inst());
endtask

`endif

//--- bench/tb_core.sv
// core testbench
`timescale 1ns/10ps
`default_nettype none

module tb_core;

  logic               clock;
  logic               reset;
  core_pkg::xlen_t    imem_addr_o;
  core_pkg::inst_t    imem_data_i;
  logic               commit_valid_o;
  core_pkg::xlen_t    commit_pc_o;
  core_pkg::inst_t    commit_inst_o;
  logic               commit_wen_o;
  core_pkg::reg_idx_t commit_wdest_o;
  core_pkg::xlen_t    commit_wdata_o;
  logic               trap_o;
  logic [7:0]         trap_code_o;
  core_pkg::xlen_t    cycle_count_o;
  core_pkg::xlen_t    instr_count_o;

  core_pkg::inst_t    rom [64];
  core_pkg::xlen_t    shadow_reg [32];
  core_pkg::xlen_t    shadow_mem [32];
  core_pkg::xlen_t    exp_pc;
  core_pkg::xlen_t    commits;
  core_pkg::xlen_t    frozen_cycles;
  core_pkg::xlen_t    elapsed;
  logic               trapped;
  logic [15:0]        lfsr_state = 16'd55332;
  int                 gap;
  int                 cycles = 0;
  int                 errors = 0;
  int                 prog_len;
  int                 limit;

  core_top i_dut (
    .clock          (clock),
    .reset          (reset),
    .imem_addr_o    (imem_addr_o),
    .imem_data_i    (imem_data_i),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_inst_o  (commit_inst_o),
    .commit_wen_o   (commit_wen_o),
    .commit_wdest_o (commit_wdest_o),
    .commit_wdata_o (commit_wdata_o),
    .trap_o         (trap_o),
    .trap_code_o    (trap_code_o),
    .cycle_count_o  (cycle_count_o),
    .instr_count_o  (instr_count_o)
  );

  assign imem_data_i = rom[imem_addr_o[7:2]];

  // galois lfsr stepped once per random bit
  function automatic logic lfsr_step();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hb400;
    end
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  task automatic append_inst(input core_pkg::inst_t w);
    rom[prog_len] = w;
    prog_len++;
  endtask

  `include "tb_program.svh"

  task automatic flag_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  function automatic core_pkg::xlen_t alu_model(input logic [2:0] f3, input core_pkg::xlen_t a,
                                                input core_pkg::xlen_t b, input logic sub);
    case (f3)
      3'b111:  return a & b;
      3'b110:  return a | b;
      3'b100:  return a ^ b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  function automatic logic expected_wen(input core_pkg::inst_t inst);
    return inst[6:0] == core_pkg::OPC_OP_IMM || inst[6:0] == core_pkg::OPC_OP ||
           inst[6:0] == core_pkg::OPC_LUI || inst[6:0] == core_pkg::OPC_LOAD ||
           inst[6:0] == core_pkg::OPC_JAL;
  endfunction

  function automatic core_pkg::xlen_t expected_value(input core_pkg::inst_t inst,
                                                     input core_pkg::xlen_t pc);
    core_pkg::xlen_t a, imm, addr;
    a = shadow_reg[inst[19:15]];
    imm = {{52{inst[31]}}, inst[31:20]};
    addr = a + imm;
    case (inst[6:0])
      core_pkg::OPC_OP_IMM: return alu_model(inst[14:12], a, imm, 1'b0);
      core_pkg::OPC_OP:     return alu_model(inst[14:12], a, shadow_reg[inst[24:20]], inst[30]);
      core_pkg::OPC_LUI:    return {{32{inst[31]}}, inst[31:12], 12'b0};
      core_pkg::OPC_LOAD:   return shadow_mem[addr[7:3]];
      core_pkg::OPC_JAL:    return pc + 64'd4;
      default:              return '0;
    endcase
  endfunction

  // doubleword index of a store
  function automatic logic [4:0] store_word(input core_pkg::inst_t inst);
    core_pkg::xlen_t addr;
    addr = shadow_reg[inst[19:15]] + {{52{inst[31]}}, inst[31:25], inst[11:7]};
    return addr[7:3];
  endfunction

  function automatic core_pkg::xlen_t next_pc_of(input core_pkg::inst_t inst,
                                                 input core_pkg::xlen_t pc);
    logic equal;
    equal = shadow_reg[inst[19:15]] == shadow_reg[inst[24:20]];
    if (inst[6:0] == core_pkg::OPC_JAL) begin
      return pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    if (inst[6:0] == core_pkg::OPC_BRANCH &&
        ((inst[14:12] == 3'b000 && equal) || (inst[14:12] == 3'b001 && !equal))) begin
      return pc + {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    end
    return pc + 64'd4;
  endfunction

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
  end

  // cycles since reset released
  always @(posedge clock) begin
    if (reset) begin
      elapsed <= '0;
    end else begin
      elapsed <= elapsed + 64'd1;
    end
  end

  // shadow model steps once per commit pulse
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        shadow_reg[i] <= '0;
        shadow_mem[i] <= '0;
      end
      exp_pc        <= '0;
      commits       <= '0;
      frozen_cycles <= '0;
      trapped       <= 1'b0;
      gap           <= 0;
    end else begin
      gap <= commit_valid_o ? 1 : gap + 1;
      if (commit_valid_o) begin
        commits <= commits + 64'd1;
        exp_pc  <= next_pc_of(commit_inst_o, commit_pc_o);
        if (expected_wen(commit_inst_o) && commit_inst_o[11:7] != 5'd0) begin
          shadow_reg[commit_inst_o[11:7]] <= expected_value(commit_inst_o, commit_pc_o);
        end
        if (commit_inst_o[6:0] == core_pkg::OPC_STORE) begin
          shadow_mem[store_word(commit_inst_o)] <= shadow_reg[commit_inst_o[24:20]];
        end
        if (commit_inst_o[6:0] == core_pkg::OPC_TRAP) begin
          trapped       <= 1'b1;
          frozen_cycles <= cycle_count_o;
        end
      end
    end
  end

  reset_state: assert property (@(negedge clock) reset |->
      !commit_valid_o && !trap_o && cycle_count_o == '0 && instr_count_o == '0 &&
      imem_addr_o == '0)
    else flag_error("state not cleared during reset");

  pc_follows: assert property (@(negedge clock) disable iff (reset)
      commit_valid_o |-> commit_pc_o == exp_pc && commit_inst_o == rom[commit_pc_o[7:2]])
    else flag_error($sformatf("commit pc %h, expected %h", commit_pc_o, exp_pc));

  write_matches: assert property (@(negedge clock) disable iff (reset)
      commit_valid_o |-> commit_wen_o == expected_wen(commit_inst_o) &&
      (!commit_wen_o || (commit_wdest_o == commit_inst_o[11:7] &&
      commit_wdata_o == expected_value(commit_inst_o, commit_pc_o))))
    else flag_error($sformatf("pc %h wen %b x%0d = %h, expected %h", commit_pc_o,
                              commit_wen_o, commit_wdest_o, commit_wdata_o,
                              expected_value(commit_inst_o, commit_pc_o)));

  // one instruction per eight cycles
  commit_spacing: assert property (@(negedge clock) disable iff (reset)
      commit_valid_o |-> gap == 8)
    else flag_error($sformatf("commit after %0d cycles", gap));

  retire_count: assert property (@(negedge clock) disable iff (reset)
      instr_count_o == commits + 64'(commit_valid_o))
    else flag_error($sformatf("instr_count %0d, seen %0d", instr_count_o, commits));

  cycle_tracks: assert property (@(negedge clock) disable iff (reset)
      !trapped |-> cycle_count_o == elapsed)
    else flag_error($sformatf("cycle_count %0d, expected %0d", cycle_count_o, elapsed));

  trap_code: assert property (@(negedge clock) disable iff (reset)
      commit_valid_o && commit_inst_o[6:0] == core_pkg::OPC_TRAP |->
      trap_o && trap_code_o == shadow_reg[10][7:0])
    else flag_error($sformatf("trap %b code %h, expected %h", trap_o, trap_code_o,
                              shadow_reg[10][7:0]));

  no_early_trap: assert property (@(negedge clock) disable iff (reset)
      !trapped && !(commit_valid_o && commit_inst_o[6:0] == core_pkg::OPC_TRAP) |-> !trap_o)
    else flag_error("trap_o set before the trap instruction");

  halted: assert property (@(negedge clock) disable iff (reset)
      trapped |-> !commit_valid_o && trap_o && cycle_count_o == frozen_cycles)
    else flag_error($sformatf("core still running after trap, cycles %0d", cycle_count_o));

  initial begin
    reset = 1'b1;
    load_program();
    limit = prog_len * 8 + 32;
    repeat (2) @(posedge clock);
    #1 reset = 1'b0;
    while (!trapped && cycles < limit) begin
      @(posedge clock);
    end
    if (trapped) begin
      repeat (16) @(posedge clock);
    end
    $display("commits: %0d  errors: %0d", commits, errors);
    if (!trapped) begin
      $display("timeout: core did not trap within %0d cycles", limit);
      $display("*** TEST FAILED ***");
    end else if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
source/core_pkg.sv
source/phase_counter.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/reg_file.sv
source/mem_stage.sv
source/core_top.sv
bench/tb_core.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing
TOP       := tb_core
FILELIST  := tb.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
